// File: compile.f
+incdir+source
source/funcgen_pkg.sv
source/spi_txn_if.sv
source/word_stream_if.sv
source/spi_command_slave.sv
source/control_registers.sv
source/waveform_memory.sv
source/playback_sequencer.sv
source/word_serializer.sv
source/funcgen_top.sv
verif/funcgen_asserts.sv
verif/funcgen_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the funcgen testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module funcgen_tb -o funcgen_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/funcgen_sim +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$run_status" -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0

// File: source/control_registers.sv
`timescale 1ns/100ps
`include "funcgen_config.svh"

module control_registers (
	input  logic clock_ro,
	input  logic reset4_word_clock,
	spi_txn_if.target txn,
	output logic [15:0] start_address,
	output logic [15:0] end_address,
	output logic enable
);
	logic in_range;
	funcgen_pkg::reg_index_e index;

	// upper address bits must be zero as well
	assign in_range = (txn.address < 16'(`FG_NUM_REGS));
	assign index = funcgen_pkg::reg_index_e'(txn.address[1:0]);

	// --------------------
	// writes land the cycle after valid
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			start_address <= '0;
			end_address <= '0;
			enable <= 1'b0;
		end else if (txn.valid && txn.command == funcgen_pkg::CMD_WRITE && in_range) begin
			case (index)
				funcgen_pkg::REG_START:  start_address <= txn.wdata[15:0];
				funcgen_pkg::REG_END:    end_address <= txn.wdata[15:0];
				funcgen_pkg::REG_ENABLE: enable <= txn.wdata[0];
				default: ;
			endcase
		end
	end

	// readback, out of range reads zero
	always_comb begin
		txn.rdata = '0;
		if (in_range) begin
			case (index)
				funcgen_pkg::REG_START:  txn.rdata = {16'h0000, start_address};
				funcgen_pkg::REG_END:    txn.rdata = {16'h0000, end_address};
				funcgen_pkg::REG_ENABLE: txn.rdata = {31'd0, enable};
				default: txn.rdata = '0;
			endcase
		end
	end
endmodule

// File: source/funcgen_config.svh
`ifndef FUNCGEN_CONFIG_SVH
`define FUNCGEN_CONFIG_SVH

// waveform memory depth in 32-bit words
// 1024 words gives 4096 playback bytes
`define FG_MEM_WORDS 1024

// serializer buffer slots, also the starting credit of the sequencer
`define FG_CREDITS 4

// spi frame: 8 command + 16 address + 32 data bits
`define FG_FRAME_BITS 56

// control registers behind chip select 0
`define FG_NUM_REGS 3

`endif

// File: source/funcgen_pkg.sv
package funcgen_pkg;

	// --------------------
	// spi opcodes
	// anything not listed acts like a read
	typedef enum logic [7:0] {
		CMD_READ  = 8'h01,
		CMD_WRITE = 8'h02
	} spi_cmd_e;

	// --------------------
	// control register map
	// start and end are byte addresses, end is exclusive
	typedef enum logic [1:0] {
		REG_START  = 2'd0,
		REG_END    = 2'd1,
		REG_ENABLE = 2'd2
	} reg_index_e;

	// --------------------
	// serializer FSM
	typedef enum logic {
		SER_IDLE,
		SER_SHIFT
	} ser_state_e;

endpackage

// File: source/funcgen_top.sv
`timescale 1ns/100ps

module funcgen_top (
	input  logic clock_ro,
	input  logic reset4_word_clock,
	input  logic spi_sclk,
	input  logic spi_mosi,
	input  logic spi_ce0_n,
	input  logic spi_ce1_n,
	output logic spi_miso,
	output logic serial_out,
	output logic sync_out
);
	logic miso_ce0;
	logic miso_ce1;
	logic [15:0] start_address;
	logic [15:0] end_address;
	logic enable;
	logic [11:0] read_address;
	logic [7:0] read_byte;

	spi_txn_if txn_ce0 ();
	spi_txn_if txn_ce1 ();
	word_stream_if stream ();

	// --------------------
	// chip select 0 reaches the register bank
	spi_command_slave spi_ce0 (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.sclk(spi_sclk), .mosi(spi_mosi), .ce_n(spi_ce0_n), .miso(miso_ce0),
		.txn(txn_ce0.slave)
	);
	control_registers regs (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock), .txn(txn_ce0.target),
		.start_address(start_address), .end_address(end_address), .enable(enable)
	);

	// chip select 1 reaches waveform memory
	spi_command_slave spi_ce1 (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.sclk(spi_sclk), .mosi(spi_mosi), .ce_n(spi_ce1_n), .miso(miso_ce1),
		.txn(txn_ce1.slave)
	);
	waveform_memory mem (
		.clock_ro(clock_ro), .txn(txn_ce1.target),
		.read_address(read_address), .read_byte(read_byte)
	);

	// --------------------
	// playback chain
	playback_sequencer seq (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.start_address(start_address), .end_address(end_address), .enable(enable),
		.read_address(read_address), .read_byte(read_byte), .stream(stream.source)
	);
	word_serializer ser (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.stream(stream.sink), .serial_out(serial_out), .sync_out(sync_out)
	);

	// selected slave drives miso, 0 when neither
	assign spi_miso = !spi_ce0_n ? miso_ce0 : (!spi_ce1_n ? miso_ce1 : 1'b0);
endmodule

// File: source/playback_sequencer.sv
`timescale 1ns/100ps
`include "funcgen_config.svh"

module playback_sequencer (
	input  logic clock_ro,
	input  logic reset4_word_clock,
	input  logic [15:0] start_address,
	input  logic [15:0] end_address,
	input  logic enable,
	output logic [11:0] read_address,
	input  logic [7:0] read_byte,
	word_stream_if.source stream
);
	localparam int CREDIT_BITS = $clog2(`FG_CREDITS + 1);

	logic [11:0] address_q;
	// end minus one, latched on every reload
	logic [11:0] last_q;
	logic at_start_q;
	logic request_q;
	logic first_q;
	logic [CREDIT_BITS-1:0] credit_count;
	logic active;
	logic issue;

	assign active = enable && (end_address > start_address);
	// a read already in flight holds one credit
	assign issue = active && (credit_count > CREDIT_BITS'(request_q));

	// --------------------
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			address_q <= start_address[11:0];
			last_q <= 12'(end_address - 16'd1);
			at_start_q <= 1'b1;
			request_q <= 1'b0;
			first_q <= 1'b0;
			credit_count <= CREDIT_BITS'(`FG_CREDITS);
		end else begin
			request_q <= issue;
			first_q <= issue && at_start_q;
			// valid spends, credit pulse refunds
			credit_count <= credit_count - CREDIT_BITS'(stream.valid)
				+ CREDIT_BITS'(stream.credit);
			// idle or wrapping: back to start
			if (!active || (issue && address_q == last_q)) begin
				address_q <= start_address[11:0];
				last_q <= 12'(end_address - 16'd1);
				at_start_q <= 1'b1;
			end else if (issue) begin
				address_q <= address_q + 12'd1;
				at_start_q <= 1'b0;
			end
		end
	end

	assign read_address = address_q;

	// memory byte lines up with the delayed request
	assign stream.valid = request_q;
	assign stream.byte_data = read_byte;
	assign stream.first = first_q;
endmodule

// File: source/spi_command_slave.sv
`timescale 1ns/100ps
`include "funcgen_config.svh"

module spi_command_slave (
	input  logic clock_ro,
	input  logic reset4_word_clock,
	input  logic sclk,
	input  logic mosi,
	input  logic ce_n,
	output logic miso,
	spi_txn_if.slave txn
);
	localparam int COUNT_BITS = $clog2(`FG_FRAME_BITS);
	localparam int CMD_END = 8;
	localparam int ADDR_END = 24;

	logic [2:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [1:0] ce_sync;
	logic selected;
	logic sclk_rise;
	logic sclk_fall;
	logic [COUNT_BITS-1:0] bit_count;
	logic frame_done;
	logic address_done;
	logic valid_q;
	logic [7:0] command_q;
	logic [15:0] address_q;
	logic [31:0] data_q;
	logic [31:0] miso_shift;
	logic miso_q;

	// --------------------
	// two-flop synchronizers, sclk gets a third stage for edge detect
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			sclk_sync <= '0;
			mosi_sync <= '0;
			ce_sync <= 2'b11;
		end else begin
			sclk_sync <= {sclk_sync[1:0], sclk};
			mosi_sync <= {mosi_sync[0], mosi};
			ce_sync <= {ce_sync[0], ce_n};
		end
	end

	assign selected = ~ce_sync[1];
	assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];

	// --------------------
	// bit counter, short frames are dropped when ce goes high
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			bit_count <= '0;
			frame_done <= 1'b0;
			address_done <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			address_done <= 1'b0;
			// valid one cycle behind frame_done
			valid_q <= frame_done;
			if (!selected) begin
				bit_count <= '0;
			end else if (sclk_rise) begin
				if (bit_count == COUNT_BITS'(`FG_FRAME_BITS - 1)) begin
					bit_count <= '0;
					frame_done <= 1'b1;
				end else begin
					bit_count <= bit_count + 1'b1;
				end
				// last address bit taken this edge
				if (bit_count == COUNT_BITS'(ADDR_END - 1))
					address_done <= 1'b1;
			end
		end
	end

	// field shift registers, msb first
	always_ff @(posedge clock_ro) begin
		if (selected && sclk_rise) begin
			if (bit_count < COUNT_BITS'(CMD_END))
				command_q <= {command_q[6:0], mosi_sync[1]};
			else if (bit_count < COUNT_BITS'(ADDR_END))
				address_q <= {address_q[14:0], mosi_sync[1]};
			else
				data_q <= {data_q[30:0], mosi_sync[1]};
		end
	end

	// --------------------
	// miso path, rdata captured once address is in
	always_ff @(posedge clock_ro) begin
		if (!selected)
			miso_shift <= '0;
		else if (address_done)
			miso_shift <= txn.rdata;
		else if (sclk_fall)
			miso_shift <= {miso_shift[30:0], 1'b0};
	end

	// mode 0, change on falling sck
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock)
			miso_q <= 1'b0;
		else if (!selected)
			miso_q <= 1'b0;
		else if (sclk_fall)
			miso_q <= miso_shift[31];
	end

	assign miso = miso_q;
	assign txn.valid = valid_q;
	assign txn.command = funcgen_pkg::spi_cmd_e'(command_q);
	assign txn.address = address_q;
	assign txn.wdata = data_q;
endmodule

// File: source/spi_txn_if.sv
`timescale 1ns/100ps

// one decoded spi frame plus the read data the target returns
interface spi_txn_if;
	// one-cycle pulse at the end of a full frame
	logic valid;
	funcgen_pkg::spi_cmd_e command;
	// held stable through the data phase
	logic [15:0] address;
	logic [31:0] wdata;
	// combinational from address, driven by the target
	logic [31:0] rdata;

	modport slave (
		output valid, command, address, wdata,
		input  rdata
	);
	modport target (
		input  valid, command, address, wdata,
		output rdata
	);
endinterface

// File: source/waveform_memory.sv
`timescale 1ns/100ps
`include "funcgen_config.svh"

module waveform_memory (
	input  logic clock_ro,
	spi_txn_if.target txn,
	input  logic [11:0] read_address,
	output logic [7:0] read_byte
);
	localparam int WORD_BITS = $clog2(`FG_MEM_WORDS);

	logic [31:0] mem [`FG_MEM_WORDS];
	logic [WORD_BITS-1:0] spi_word;
	logic [31:0] play_word;

	// spi side addresses whole words, upper bits ignored
	assign spi_word = txn.address[WORD_BITS-1:0];

	// --------------------
	// spi write port
	always_ff @(posedge clock_ro) begin
		if (txn.valid && txn.command == funcgen_pkg::CMD_WRITE)
			mem[spi_word] <= txn.wdata;
	end

	// readback follows the held address
	assign txn.rdata = mem[spi_word];

	// --------------------
	// playback port, one cycle latency
	// byte 4w is bits 31:24
	assign play_word = mem[read_address[WORD_BITS+1:2]];

	always_ff @(posedge clock_ro) begin
		case (read_address[1:0])
			2'd0: read_byte <= play_word[31:24];
			2'd1: read_byte <= play_word[23:16];
			2'd2: read_byte <= play_word[15:8];
			default: read_byte <= play_word[7:0];
		endcase
	end
endmodule

// File: source/word_serializer.sv
`timescale 1ns/100ps
`include "funcgen_config.svh"

module word_serializer (
	input  logic clock_ro,
	input  logic reset4_word_clock,
	word_stream_if.sink stream,
	output logic serial_out,
	output logic sync_out
);
	localparam int DEPTH = `FG_CREDITS;
	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	logic [7:0] fifo_byte [DEPTH];
	logic fifo_first [DEPTH];
	logic [PTR_BITS-1:0] write_ptr;
	logic [PTR_BITS-1:0] read_ptr;
	logic [COUNT_BITS-1:0] fifo_count;
	funcgen_pkg::ser_state_e state;
	logic [7:0] shift_q;
	logic [2:0] bit_count;
	logic first_q;
	logic load;

	// take next byte when idle or on the last bit, no gap between bytes
	assign load = (fifo_count != '0)
		&& ((state == funcgen_pkg::SER_IDLE) || (bit_count == 3'd7));

	// --------------------
	// buffer, never overflows while credit is honoured
	always_ff @(posedge clock_ro) begin
		if (stream.valid) begin
			fifo_byte[write_ptr] <= stream.byte_data;
			fifo_first[write_ptr] <= stream.first;
		end
	end

	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			write_ptr <= '0;
			read_ptr <= '0;
			fifo_count <= '0;
		end else begin
			if (stream.valid)
				write_ptr <= (write_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
			if (load)
				read_ptr <= (read_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
			fifo_count <= fifo_count + COUNT_BITS'(stream.valid) - COUNT_BITS'(load);
		end
	end

	// --------------------
	// shifter FSM
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			state <= funcgen_pkg::SER_IDLE;
			bit_count <= '0;
		end else if (load) begin
			state <= funcgen_pkg::SER_SHIFT;
			bit_count <= '0;
		end else if (state == funcgen_pkg::SER_SHIFT) begin
			// wraps back to 0 after bit 7
			if (bit_count == 3'd7)
				state <= funcgen_pkg::SER_IDLE;
			bit_count <= bit_count + 3'd1;
		end
	end

	always_ff @(posedge clock_ro) begin
		if (load) begin
			shift_q <= fifo_byte[read_ptr];
			first_q <= fifo_first[read_ptr];
		end else begin
			shift_q <= {shift_q[6:0], 1'b0};
		end
	end

	// msb first, quiet when nothing is shifting
	assign serial_out = (state == funcgen_pkg::SER_SHIFT) && shift_q[7];
	assign sync_out = (state == funcgen_pkg::SER_SHIFT) && first_q && (bit_count == 3'd0);
	assign stream.credit = load;
endmodule

// File: source/word_stream_if.sv
`timescale 1ns/100ps

// byte stream from sequencer to serializer under credit control
interface word_stream_if;
	logic       valid;
	logic [7:0] byte_data;
	// first byte of a playback loop
	logic       first;
	// one pulse per byte the serializer takes out of its buffer
	logic       credit;

	modport source (
		output valid, byte_data, first,
		input  credit
	);
	modport sink (
		input  valid, byte_data, first,
		output credit
	);
endinterface

// File: verif/funcgen_asserts.sv
`timescale 1ns/100ps
`include "funcgen_config.svh"

module funcgen_asserts (
	input logic clock_ro,
	input logic reset4_word_clock,
	input logic serial_out,
	input logic sync_out,
	input logic stream_valid,
	input logic [$clog2(`FG_CREDITS + 1)-1:0] credit_count,
	input logic [$clog2(`FG_CREDITS + 1)-1:0] fifo_count,
	input funcgen_pkg::ser_state_e ser_state,
	input logic ce0_valid,
	input logic ce1_valid
);
	// failures seen so far, watched from the testbench top
	int failure_count = 0;

	// --------------------
	// serializer outputs
	// idle with an empty buffer, nothing can start shifting on the next cycle
	idle_outputs_quiet: assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		(ser_state == funcgen_pkg::SER_IDLE && fifo_count == '0) |=> (!sync_out && !serial_out))
	else begin
		failure_count = failure_count + 1;
		$error("sync_out or serial_out high while serializer idles with empty buffer");
	end

	// flops have seen reset one edge earlier
	reset_outputs_low: assert property (@(posedge clock_ro)
		$past(reset4_word_clock) |-> (!serial_out && !sync_out))
	else begin
		failure_count = failure_count + 1;
		$error("serial_out or sync_out high during reset");
	end

	// --------------------
	// credit flow
	valid_needs_credit: assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		stream_valid |-> (credit_count != '0))
	else begin
		failure_count = failure_count + 1;
		$error("sequencer valid with zero credit");
	end

	credit_bounded: assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		credit_count <= ($clog2(`FG_CREDITS + 1))'(`FG_CREDITS))
	else begin
		failure_count = failure_count + 1;
		$error("credit counter above buffer depth");
	end

	// --------------------
	// spi valid is a single-cycle pulse
	ce0_valid_pulse: assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		ce0_valid |=> !ce0_valid)
	else begin
		failure_count = failure_count + 1;
		$error("chip select 0 valid longer than one cycle");
	end

	ce1_valid_pulse: assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		ce1_valid |=> !ce1_valid)
	else begin
		failure_count = failure_count + 1;
		$error("chip select 1 valid longer than one cycle");
	end
endmodule

bind funcgen_top funcgen_asserts protocol_checks (
	.clock_ro(clock_ro),
	.reset4_word_clock(reset4_word_clock),
	.serial_out(serial_out),
	.sync_out(sync_out),
	.stream_valid(stream.valid),
	.credit_count(seq.credit_count),
	.fifo_count(ser.fifo_count),
	.ser_state(ser.state),
	.ce0_valid(txn_ce0.valid),
	.ce1_valid(txn_ce1.valid)
);

// File: verif/funcgen_tb.sv
`timescale 1ns/100ps
`include "funcgen_config.svh"

module funcgen_tb;
	// words written before playback, covers every start and end used below
	localparam int PLAY_WORDS = 32;

	logic clock_ro;
	logic reset4_word_clock;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_ce0_n;
	logic spi_ce1_n;
	logic spi_miso;
	logic serial_out;
	logic sync_out;

	logic [31:0] model_mem [PLAY_WORDS];
	logic [15:0] start_value;
	logic [15:0] end_value;
	logic [31:0] read_data;

	funcgen_top UUT (
		.clock_ro(clock_ro),
		.reset4_word_clock(reset4_word_clock),
		.spi_sclk(spi_sclk),
		.spi_mosi(spi_mosi),
		.spi_ce0_n(spi_ce0_n),
		.spi_ce1_n(spi_ce1_n),
		.spi_miso(spi_miso),
		.serial_out(serial_out),
		.sync_out(sync_out)
	);

	initial begin
		clock_ro = 1'b0;
		forever #5 clock_ro = ~clock_ro;
	end

	// --------------------
	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		assert (got === expected) else begin
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, expected);
			abort_run();
		end
	endtask

	// inputs change 1 ns after the edge
	task automatic next_cycle(input int count);
		repeat (count) @(posedge clock_ro);
		#1;
	endtask

	// mode 0 frame, sck at clock_ro/10
	task automatic spi_transfer(input logic chip, input logic [7:0] command,
		input logic [15:0] address, input logic [31:0] wdata, output logic [31:0] rdata);
		logic [`FG_FRAME_BITS-1:0] frame;
		int i;
		frame = {command, address, wdata};
		rdata = '0;
		spi_ce0_n = chip;
		spi_ce1_n = !chip;
		for (i = `FG_FRAME_BITS - 1; i >= 0; i--) begin
			spi_mosi = frame[i];
			next_cycle(5);
			spi_sclk = 1'b1;
			// data phase, miso settled since the last falling edge
			if (i < 32)
				rdata = {rdata[30:0], spi_miso};
			next_cycle(5);
			spi_sclk = 1'b0;
		end
		next_cycle(5);
		spi_ce0_n = 1'b1;
		spi_ce1_n = 1'b1;
		spi_mosi = 1'b0;
		next_cycle(5);
	endtask

	task automatic write_word(input logic chip, input logic [15:0] address,
		input logic [31:0] data);
		logic [31:0] discarded;
		spi_transfer(chip, funcgen_pkg::CMD_WRITE, address, data, discarded);
	endtask

	// byte 4w is the top byte of word w
	function automatic logic [7:0] expected_byte(input int address);
		logic [31:0] word;
		word = model_mem[address / 4];
		return word[8 * (3 - address % 4) +: 8];
	endfunction

	// --------------------
	// follow serial_out across several loops, gaps allowed
	task automatic check_playback(input int loops);
		int total;
		int count;
		int bit_index;
		int address;
		int timeout;
		logic [7:0] got;
		total = loops * (end_value - start_value);
		timeout = 0;
		while (sync_out !== 1'b1) begin
			next_cycle(1);
			timeout++;
			if (timeout > 400) begin
				$display("timed out waiting for sync_out after playback was enabled");
				abort_run();
			end
		end
		count = 0;
		bit_index = 0;
		address = start_value;
		got = '0;
		timeout = 0;
		while (count < total) begin
			if (UUT.ser.state == funcgen_pkg::SER_SHIFT) begin
				// sync only on bit 7 of the start byte
				check_equal(sync_out, (bit_index == 0 && address == start_value), "sync_out");
				got = {got[6:0], serial_out};
				bit_index++;
				timeout = 0;
				if (bit_index == 8) begin
					check_equal(got, expected_byte(address), "playback byte");
					bit_index = 0;
					count++;
					address = (address + 1 == end_value) ? start_value : address + 1;
				end
			end else begin
				check_equal(sync_out, 1'b0, "sync_out between bytes");
				check_equal(serial_out, 1'b0, "serial_out between bytes");
				timeout++;
				if (timeout > 100) begin
					$display("timed out waiting for the next playback bit");
					abort_run();
				end
			end
			next_cycle(1);
		end
	endtask

	// any bound assertion failure ends the run
	always @(posedge clock_ro) begin
		if (UUT.protocol_checks.failure_count != 0) begin
			$display("a protocol assertion bound into funcgen_top failed");
			abort_run();
		end
	end

	// --------------------
	initial begin
		int i;
		int timeout;
		void'($urandom(32'h902e_c4ab));
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_ce0_n = 1'b1;
		spi_ce1_n = 1'b1;
		reset4_word_clock = 1'b1;
		next_cycle(16);
		reset4_word_clock = 1'b0;
		next_cycle(4);

		// control registers over chip select 0
		start_value = 16'($urandom % 64);
		end_value = start_value + 16'd5 + 16'($urandom % 12);
		write_word(1'b0, 16'(funcgen_pkg::REG_START), {16'h0000, start_value});
		write_word(1'b0, 16'(funcgen_pkg::REG_END), {16'h0000, end_value});
		write_word(1'b0, 16'd3, 32'hffff_ffff);
		spi_transfer(1'b0, funcgen_pkg::CMD_READ, 16'(funcgen_pkg::REG_START), 32'h0, read_data);
		check_equal(read_data, {16'h0000, start_value}, "start register");
		spi_transfer(1'b0, funcgen_pkg::CMD_READ, 16'(funcgen_pkg::REG_END), 32'h0, read_data);
		check_equal(read_data, {16'h0000, end_value}, "end register");
		spi_transfer(1'b0, funcgen_pkg::CMD_READ, 16'(funcgen_pkg::REG_ENABLE), 32'h0, read_data);
		check_equal(read_data, 32'h0, "enable register");
		spi_transfer(1'b0, funcgen_pkg::CMD_READ, 16'd3, 32'h0, read_data);
		check_equal(read_data, 32'h0, "register address 3");

		// waveform memory over chip select 1
		for (i = 0; i < PLAY_WORDS; i++) begin
			model_mem[i] = $urandom;
			write_word(1'b1, 16'(i), model_mem[i]);
		end
		for (i = 0; i < PLAY_WORDS; i++) begin
			spi_transfer(1'b1, funcgen_pkg::CMD_READ, 16'(i), 32'h0, read_data);
			check_equal(read_data, model_mem[i], "waveform word");
		end
		// read frame carries data that must not land
		spi_transfer(1'b1, funcgen_pkg::CMD_READ, 16'd5, ~model_mem[5], read_data);
		spi_transfer(1'b1, funcgen_pkg::CMD_READ, 16'd5, 32'h0, read_data);
		check_equal(read_data, model_mem[5], "word after read-only frame");

		// playback
		write_word(1'b0, 16'(funcgen_pkg::REG_ENABLE), 32'h1);
		spi_transfer(1'b0, funcgen_pkg::CMD_READ, 16'(funcgen_pkg::REG_ENABLE), 32'h0, read_data);
		check_equal(read_data, 32'h1, "enable register after write");
		check_playback(3);

		// disable, drain, then quiet output
		write_word(1'b0, 16'(funcgen_pkg::REG_ENABLE), 32'h0);
		timeout = 0;
		while (UUT.ser.state != funcgen_pkg::SER_IDLE || UUT.ser.fifo_count != 0) begin
			next_cycle(1);
			timeout++;
			if (timeout > 100) begin
				$display("timed out waiting for the serializer to drain");
				abort_run();
			end
		end
		for (i = 0; i < 200; i++) begin
			check_equal(serial_out, 1'b0, "serial_out while disabled");
			check_equal(sync_out, 1'b0, "sync_out while disabled");
			next_cycle(1);
		end

		if (UUT.protocol_checks.failure_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("a protocol assertion failed during the run");
			abort_run();
		end
	end
endmodule
